// File: source/oflow_pkg.sv
// oflow package with the shared widths, register map and pipeline types of the scorer
`default_nettype none

package oflow_pkg;

	// ----------------------------------------------------------
	// widths
	// ----------------------------------------------------------
	localparam int ADDR_LEN                    = 8;
	localparam int APB_DATA_LEN                = 32;
	localparam int WEIGHT_LEN                  = 8;
	localparam int SCORE_LEN                   = 24;
	localparam int NUM_OF_HISTORY_FRAMES_WIDTH = 3;
	localparam int COORD_LEN                   = 8;
	localparam int OVERLAP_LEN                 = 10;
	localparam int TRACK_ID_LEN                = 4;

	// plain vector types
	typedef logic [ADDR_LEN-1:0]                    apb_addr_t;
	typedef logic [APB_DATA_LEN-1:0]                apb_data_t;
	typedef logic [WEIGHT_LEN-1:0]                  weight_t;
	typedef logic [SCORE_LEN-1:0]                   score_t;
	typedef logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] hist_len_t;
	typedef logic [COORD_LEN-1:0]                   coord_t;
	typedef logic [OVERLAP_LEN-1:0]                 overlap_t;
	typedef logic [TRACK_ID_LEN-1:0]                track_id_t;

	// ----------------------------------------------------------
	// register map, word aligned
	// ----------------------------------------------------------
	localparam apb_addr_t W_IOU_ADDR                 = 8'h00;
	localparam apb_addr_t W_WIDTH_ADDR               = 8'h04;
	localparam apb_addr_t W_HEIGHT_ADDR              = 8'h08;
	localparam apb_addr_t W_COLOR1_ADDR              = 8'h0C;
	localparam apb_addr_t W_COLOR2_ADDR              = 8'h10;
	localparam apb_addr_t W_HISTORY_ADDR             = 8'h14;
	localparam apb_addr_t SCORE_TH_FOR_NEW_BBOX_ADDR = 8'h18;
	localparam apb_addr_t NUM_OF_HISTORY_FRAMES_ADDR = 8'h1C;

	// full-scale similarity for one size or color feature
	localparam coord_t COORD_MAX = '1;

	// ----------------------------------------------------------
	// structs
	// ----------------------------------------------------------
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t width;
		coord_t height;
		coord_t color1;
		coord_t color2;
	} bbox_t;

	typedef struct packed {
		bbox_t     box;
		hist_len_t age;
		track_id_t id;
	} track_t;

	typedef struct packed {
		bbox_t  det;
		track_t trk;
	} bbox_pair_t;

	typedef struct packed {
		weight_t iou;
		weight_t width;
		weight_t height;
		weight_t color1;
		weight_t color2;
		weight_t history;
	} weights_t;

	// register file output, read live by every stage
	typedef struct packed {
		weights_t  weights;
		score_t    score_th;
		hist_len_t num_frames;
	} track_cfg_t;

	typedef struct packed {
		overlap_t  overlap;
		coord_t    dw;
		coord_t    dh;
		coord_t    dc1;
		coord_t    dc2;
		hist_len_t age;
		track_id_t id;
	} feature_t;

	typedef struct packed {
		score_t    score;
		hist_len_t age;
		track_id_t id;
	} score_stage_t;

	typedef struct packed {
		track_id_t id;
		score_t    score;
		logic      match;
		logic      expired;
	} match_result_t;

endpackage

`default_nettype wire

// File: source/oflow_reg_file.sv
// oflow register file holding the APB programmed weights, threshold and history length
`timescale 1ns/1ps
`default_nettype none

module oflow_reg_file (
	input  logic                   clk,
	input  logic                   reset_N,
	// apb slave side
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  oflow_pkg::apb_addr_t   paddr,
	input  oflow_pkg::apb_data_t   pwdata,
	output logic                   pready,
	output oflow_pkg::apb_data_t   prdata,
	// configuration to the pipeline
	output oflow_pkg::track_cfg_t  cfg
);

	// ----------------------------------------------------------
	// access phase decode
	// ----------------------------------------------------------
	logic                 access;
	logic                 wr_access;
	logic                 rd_access;
	logic                 addr_hit;
	oflow_pkg::apb_data_t rd_mux;

	assign access    = psel && penable;
	assign wr_access = access && pwrite;
	assign rd_access = access && !pwrite;

	// address match and zero-extended read value
	always_comb
	begin
		addr_hit = 1'b1;
		rd_mux   = '0;
		case (paddr)
			oflow_pkg::W_IOU_ADDR:
				rd_mux = oflow_pkg::apb_data_t'(cfg.weights.iou);
			oflow_pkg::W_WIDTH_ADDR:
				rd_mux = oflow_pkg::apb_data_t'(cfg.weights.width);
			oflow_pkg::W_HEIGHT_ADDR:
				rd_mux = oflow_pkg::apb_data_t'(cfg.weights.height);
			oflow_pkg::W_COLOR1_ADDR:
				rd_mux = oflow_pkg::apb_data_t'(cfg.weights.color1);
			oflow_pkg::W_COLOR2_ADDR:
				rd_mux = oflow_pkg::apb_data_t'(cfg.weights.color2);
			oflow_pkg::W_HISTORY_ADDR:
				rd_mux = oflow_pkg::apb_data_t'(cfg.weights.history);
			oflow_pkg::SCORE_TH_FOR_NEW_BBOX_ADDR:
				rd_mux = oflow_pkg::apb_data_t'(cfg.score_th);
			oflow_pkg::NUM_OF_HISTORY_FRAMES_ADDR:
				rd_mux = oflow_pkg::apb_data_t'(cfg.num_frames);
			default:
				addr_hit = 1'b0;
		endcase
	end

	// no wait states, unmapped access never completes
	assign pready = access && addr_hit;
	assign prdata = (rd_access && addr_hit) ? rd_mux : '0;

	// ----------------------------------------------------------
	// configuration registers
	// ----------------------------------------------------------
	// each field takes the low bits of pwdata
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			cfg <= '0;
		end
		else if (wr_access)
		begin
			case (paddr)
				oflow_pkg::W_IOU_ADDR:
					cfg.weights.iou <= pwdata[oflow_pkg::WEIGHT_LEN-1:0];
				oflow_pkg::W_WIDTH_ADDR:
					cfg.weights.width <= pwdata[oflow_pkg::WEIGHT_LEN-1:0];
				oflow_pkg::W_HEIGHT_ADDR:
					cfg.weights.height <= pwdata[oflow_pkg::WEIGHT_LEN-1:0];
				oflow_pkg::W_COLOR1_ADDR:
					cfg.weights.color1 <= pwdata[oflow_pkg::WEIGHT_LEN-1:0];
				oflow_pkg::W_COLOR2_ADDR:
					cfg.weights.color2 <= pwdata[oflow_pkg::WEIGHT_LEN-1:0];
				oflow_pkg::W_HISTORY_ADDR:
					cfg.weights.history <= pwdata[oflow_pkg::WEIGHT_LEN-1:0];
				oflow_pkg::SCORE_TH_FOR_NEW_BBOX_ADDR:
					cfg.score_th <= pwdata[oflow_pkg::SCORE_LEN-1:0];
				oflow_pkg::NUM_OF_HISTORY_FRAMES_ADDR:
					cfg.num_frames <= pwdata[oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0];
				default:
				begin
					// unmapped write is dropped
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/oflow_feature_diff.sv
// oflow stage one, turns a detection/track pair into overlap and difference features
`timescale 1ns/1ps
`default_nettype none

module oflow_feature_diff (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   pair_valid,
	input  oflow_pkg::bbox_pair_t  pair,
	output logic                   feature_valid,
	output oflow_pkg::feature_t    feature
);

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	// clipped overlap of two intervals on one axis
	function automatic oflow_pkg::coord_t axis_overlap(
		input oflow_pkg::coord_t lo_a,
		input oflow_pkg::coord_t len_a,
		input oflow_pkg::coord_t lo_b,
		input oflow_pkg::coord_t len_b
	);
		logic [oflow_pkg::COORD_LEN:0] hi_a;
		logic [oflow_pkg::COORD_LEN:0] hi_b;
		logic [oflow_pkg::COORD_LEN:0] hi_min;
		logic [oflow_pkg::COORD_LEN:0] lo_max;
		logic [oflow_pkg::COORD_LEN:0] span;
		// right edges need the ninth bit
		hi_a   = {1'b0, lo_a} + {1'b0, len_a};
		hi_b   = {1'b0, lo_b} + {1'b0, len_b};
		hi_min = (hi_a < hi_b) ? hi_a : hi_b;
		lo_max = (lo_a > lo_b) ? {1'b0, lo_a} : {1'b0, lo_b};
		span   = (hi_min > lo_max) ? (hi_min - lo_max) : '0;
		// span never exceeds the shorter length, so eight bits hold it
		return span[oflow_pkg::COORD_LEN-1:0];
	endfunction

	function automatic oflow_pkg::coord_t abs_diff(
		input oflow_pkg::coord_t a,
		input oflow_pkg::coord_t b
	);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	// ----------------------------------------------------------
	// feature datapath
	// ----------------------------------------------------------
	oflow_pkg::coord_t   ov_x;
	oflow_pkg::coord_t   ov_y;
	oflow_pkg::feature_t feature_nxt;

	assign ov_x = axis_overlap(pair.det.x, pair.det.width, pair.trk.box.x, pair.trk.box.width);
	assign ov_y = axis_overlap(pair.det.y, pair.det.height, pair.trk.box.y,
		pair.trk.box.height);

	always_comb
	begin
		// summed overlap stands in for iou
		feature_nxt.overlap = oflow_pkg::overlap_t'(ov_x) + oflow_pkg::overlap_t'(ov_y);
		feature_nxt.dw      = abs_diff(pair.det.width, pair.trk.box.width);
		feature_nxt.dh      = abs_diff(pair.det.height, pair.trk.box.height);
		feature_nxt.dc1     = abs_diff(pair.det.color1, pair.trk.box.color1);
		feature_nxt.dc2     = abs_diff(pair.det.color2, pair.trk.box.color2);
		// track bookkeeping rides along
		feature_nxt.age     = pair.trk.age;
		feature_nxt.id      = pair.trk.id;
	end

	// ----------------------------------------------------------
	// stage register
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
			feature_valid <= 1'b0;
		else
			feature_valid <= pair_valid;
	end

	always_ff @(posedge clk)
	begin
		if (pair_valid)
			feature <= feature_nxt;
	end

endmodule

`default_nettype wire

// File: source/oflow_score_calc.sv
// oflow stage two, forms the weighted similarity score from the stage one features
`timescale 1ns/1ps
`default_nettype none

module oflow_score_calc (
	input  logic                     clk,
	input  logic                     reset_N,
	input  logic                     feature_valid,
	input  oflow_pkg::feature_t      feature,
	input  oflow_pkg::weights_t      weights,
	input  oflow_pkg::hist_len_t     num_frames,
	output logic                     score_valid,
	output oflow_pkg::score_stage_t  score_out
);

	// weight times factor at full score width
	function automatic oflow_pkg::score_t wmul(
		input oflow_pkg::weight_t w,
		input oflow_pkg::score_t  factor
	);
		return oflow_pkg::score_t'(w) * factor;
	endfunction

	// ----------------------------------------------------------
	// similarity factors
	// ----------------------------------------------------------
	oflow_pkg::coord_t    sim_w;
	oflow_pkg::coord_t    sim_h;
	oflow_pkg::coord_t    sim_c1;
	oflow_pkg::coord_t    sim_c2;
	oflow_pkg::hist_len_t hist_left;

	// small difference means high similarity
	assign sim_w  = oflow_pkg::COORD_MAX - feature.dw;
	assign sim_h  = oflow_pkg::COORD_MAX - feature.dh;
	assign sim_c1 = oflow_pkg::COORD_MAX - feature.dc1;
	assign sim_c2 = oflow_pkg::COORD_MAX - feature.dc2;

	// remaining history frames, clamped at zero for old tracks
	assign hist_left = (feature.age > num_frames) ? '0 : (num_frames - feature.age);

	// ----------------------------------------------------------
	// weighted terms and sum
	// ----------------------------------------------------------
	oflow_pkg::score_t term_iou;
	oflow_pkg::score_t term_w;
	oflow_pkg::score_t term_h;
	oflow_pkg::score_t term_c1;
	oflow_pkg::score_t term_c2;
	oflow_pkg::score_t term_hist;
	oflow_pkg::score_t score_sum;

	assign term_iou  = wmul(weights.iou, oflow_pkg::score_t'(feature.overlap));
	assign term_w    = wmul(weights.width, oflow_pkg::score_t'(sim_w));
	assign term_h    = wmul(weights.height, oflow_pkg::score_t'(sim_h));
	assign term_c1   = wmul(weights.color1, oflow_pkg::score_t'(sim_c1));
	assign term_c2   = wmul(weights.color2, oflow_pkg::score_t'(sim_c2));
	assign term_hist = wmul(weights.history, oflow_pkg::score_t'(hist_left));

	// worst case stays below 2^20, no overflow
	assign score_sum = term_iou + term_w + term_h + term_c1 + term_c2 + term_hist;

	// ----------------------------------------------------------
	// stage register
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
			score_valid <= 1'b0;
		else
			score_valid <= feature_valid;
	end

	always_ff @(posedge clk)
	begin
		if (feature_valid)
		begin
			score_out.score <= score_sum;
			score_out.age   <= feature.age;
			score_out.id    <= feature.id;
		end
	end

endmodule

`default_nettype wire

// File: source/oflow_match_decide.sv
// oflow stage three, applies track expiry and the score threshold to form the result
`timescale 1ns/1ps
`default_nettype none

module oflow_match_decide (
	input  logic                      clk,
	input  logic                      reset_N,
	input  logic                      score_valid,
	input  oflow_pkg::score_stage_t   score_in,
	input  oflow_pkg::score_t         score_th,
	input  oflow_pkg::hist_len_t      num_frames,
	output logic                      result_valid,
	output oflow_pkg::match_result_t  result
);

	// ----------------------------------------------------------
	// decision
	// ----------------------------------------------------------
	logic expired;
	logic above_th;
	logic match;

	// track older than the history window
	assign expired = score_in.age > num_frames;

	// threshold is inclusive
	assign above_th = score_in.score >= score_th;

	// live track with enough score continues
	// otherwise a new bbox is opened
	assign match = !expired && above_th;

	// ----------------------------------------------------------
	// stage register
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
			result_valid <= 1'b0;
		else
			result_valid <= score_valid;
	end

	// result payload only moves with a valid score
	always_ff @(posedge clk)
	begin
		if (score_valid)
		begin
			result.id      <= score_in.id;
			result.score   <= score_in.score;
			result.match   <= match;
			result.expired <= expired;
		end
	end

endmodule

`default_nettype wire

// File: source/oflow_core.sv
// oflow core, joins the APB register file and the three stage scoring pipeline
`timescale 1ns/1ps
`default_nettype none

module oflow_core (
	input  logic                      clk,
	input  logic                      reset_N,
	// apb
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  oflow_pkg::apb_addr_t      paddr,
	input  oflow_pkg::apb_data_t      pwdata,
	output logic                      pready,
	output oflow_pkg::apb_data_t      prdata,
	// candidate stream
	input  logic                      pair_valid,
	input  oflow_pkg::bbox_pair_t     pair,
	output logic                      result_valid,
	output oflow_pkg::match_result_t  result
);

	// ----------------------------------------------------------
	// internal nets
	// ----------------------------------------------------------
	oflow_pkg::track_cfg_t   cfg;
	logic                    feature_valid;
	oflow_pkg::feature_t     feature;
	logic                    score_valid;
	oflow_pkg::score_stage_t score_stage;

	// configuration registers
	oflow_reg_file reg_file_i (
		.clk     (clk),
		.reset_N (reset_N),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pready  (pready),
		.prdata  (prdata),
		.cfg     (cfg)
	);

	// ----------------------------------------------------------
	// pipeline, one cycle per stage
	// ----------------------------------------------------------
	oflow_feature_diff feature_diff_i (
		.clk           (clk),
		.reset_N       (reset_N),
		.pair_valid    (pair_valid),
		.pair          (pair),
		.feature_valid (feature_valid),
		.feature       (feature)
	);

	oflow_score_calc score_calc_i (
		.clk           (clk),
		.reset_N       (reset_N),
		.feature_valid (feature_valid),
		.feature       (feature),
		.weights       (cfg.weights),
		.num_frames    (cfg.num_frames),
		.score_valid   (score_valid),
		.score_out     (score_stage)
	);

	oflow_match_decide match_decide_i (
		.clk          (clk),
		.reset_N      (reset_N),
		.score_valid  (score_valid),
		.score_in     (score_stage),
		.score_th     (cfg.score_th),
		.num_frames   (cfg.num_frames),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

`default_nettype wire

// File: tb/oflow_clk_gen.sv
// oflow testbench clock and reset generator, 8 ns clock with a ten cycle reset
`timescale 1ns/1ps
`default_nettype none

module oflow_clk_gen (
	output logic clk,
	output logic reset_N
);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset low for ten cycles, released on a falling edge
	initial
	begin
		reset_N = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_N = 1'b1;
	end

endmodule

`default_nettype wire

// File: tb/oflow_core_tb.sv
// oflow core testbench with APB tasks, random pair stream and a scoring reference model
`timescale 1ns/1ps
`default_nettype none

module oflow_core_tb;

	// ----------------------------------------------------------
	// run length
	// ----------------------------------------------------------
	localparam int ACC_CYCLES    = 3;
	localparam int DRAIN_CYCLES  = 5;
	localparam int NUM_PAIRS     = 200;
	localparam int NUM_EXPIRED   = 20;
	localparam int NUM_TH_ROUNDS = 5;
	// reset, register tests, stream, expiry, threshold rounds, margin
	localparam int LIMIT_CYCLES = 10 + ACC_CYCLES * 36
		+ (ACC_CYCLES * 8 + NUM_PAIRS + DRAIN_CYCLES)
		+ (ACC_CYCLES * 2 + NUM_EXPIRED + DRAIN_CYCLES)
		+ (ACC_CYCLES + NUM_TH_ROUNDS * 2 * (ACC_CYCLES + 1 + DRAIN_CYCLES))
		+ 200;

	logic                     clk;
	logic                     reset_N;
	logic                     psel;
	logic                     penable;
	logic                     pwrite;
	oflow_pkg::apb_addr_t     paddr;
	oflow_pkg::apb_data_t     pwdata;
	logic                     pready;
	oflow_pkg::apb_data_t     prdata;
	logic                     pair_valid;
	oflow_pkg::bbox_pair_t    pair;
	logic                     result_valid;
	oflow_pkg::match_result_t result;

	int seed = 47;
	int cycle = 0;
	int err_count = 0;
	int pass_count = 0;
	int due_cycle;
	// register shadow, index is address / 4
	oflow_pkg::apb_data_t     shadow [8];
	oflow_pkg::match_result_t exp_q [$];
	int                       cyc_q [$];

	oflow_clk_gen clk_gen_i (
		.clk     (clk),
		.reset_N (reset_N)
	);

	oflow_core dut_i (
		.clk          (clk),
		.reset_N      (reset_N),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.pready       (pready),
		.prdata       (prdata),
		.pair_valid   (pair_valid),
		.pair         (pair),
		.result_valid (result_valid),
		.result       (result)
	);

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	task automatic note_error(input string msg);
		err_count++;
		$display("[FAIL] %0t: %s", $time, msg);
	endtask

	task automatic check_data(input string what, input oflow_pkg::apb_data_t got,
		input oflow_pkg::apb_data_t exp);
		if (got !== exp)
			note_error($sformatf("%s got 0x%08h, expected 0x%08h", what, got, exp));
		else
			pass_count++;
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			note_error($sformatf("%s got %b, expected %b", what, got, exp));
		else
			pass_count++;
	endtask

	task automatic check_result(input string what, input oflow_pkg::match_result_t got,
		input oflow_pkg::match_result_t exp);
		if (got !== exp)
			note_error($sformatf("%s got id %0d score %0d m%b e%b, expected id %0d score %0d m%b e%b",
				what, got.id, got.score, got.match, got.expired,
				exp.id, exp.score, exp.match, exp.expired));
		else
			pass_count++;
	endtask

	// ----------------------------------------------------------
	// reference model
	// ----------------------------------------------------------
	function automatic int axis_span(input int lo_a, input int len_a, input int lo_b,
		input int len_b);
		int right;
		int left;
		right = (lo_a + len_a < lo_b + len_b) ? lo_a + len_a : lo_b + len_b;
		left  = (lo_a > lo_b) ? lo_a : lo_b;
		return (right > left) ? right - left : 0;
	endfunction

	function automatic int coord_dist(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic oflow_pkg::match_result_t model_result(input oflow_pkg::bbox_pair_t p);
		int ov;
		int age;
		int nf;
		int sc;
		oflow_pkg::match_result_t r;
		age = int'(p.trk.age);
		nf  = int'(shadow[7]);
		ov  = axis_span(p.det.x, p.det.width, p.trk.box.x, p.trk.box.width)
			+ axis_span(p.det.y, p.det.height, p.trk.box.y, p.trk.box.height);
		sc  = int'(shadow[0]) * ov
			+ int'(shadow[1]) * (255 - coord_dist(p.det.width, p.trk.box.width))
			+ int'(shadow[2]) * (255 - coord_dist(p.det.height, p.trk.box.height))
			+ int'(shadow[3]) * (255 - coord_dist(p.det.color1, p.trk.box.color1))
			+ int'(shadow[4]) * (255 - coord_dist(p.det.color2, p.trk.box.color2))
			+ int'(shadow[5]) * ((age > nf) ? 0 : nf - age);
		r.id      = p.trk.id;
		r.score   = oflow_pkg::score_t'(sc);
		r.expired = age > nf;
		// at-least rule on a live track
		r.match   = !r.expired && (sc >= int'(shadow[6]));
		return r;
	endfunction

	// ----------------------------------------------------------
	// APB and stream drivers, all on the falling edge
	// ----------------------------------------------------------
	task automatic apb_access(input logic write, input oflow_pkg::apb_addr_t addr,
		input oflow_pkg::apb_data_t wdata, output logic ready, output oflow_pkg::apb_data_t rdata);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		// no wait states, the access phase completes at this edge
		@(posedge clk);
		ready = pready;
		rdata = prdata;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input oflow_pkg::apb_addr_t addr, input oflow_pkg::apb_data_t data,
		input logic exp_ready);
		logic                 rdy;
		oflow_pkg::apb_data_t rd;
		apb_access(1'b1, addr, data, rdy, rd);
		check_flag($sformatf("pready on write to 0x%02h", addr), rdy, exp_ready);
		// read data stays zero on any write
		check_data($sformatf("prdata on write to 0x%02h", addr), rd, '0);
	endtask

	task automatic apb_read(input oflow_pkg::apb_addr_t addr, input logic exp_ready,
		output oflow_pkg::apb_data_t data);
		logic rdy;
		apb_access(1'b0, addr, '0, rdy, data);
		check_flag($sformatf("pready on read of 0x%02h", addr), rdy, exp_ready);
	endtask

	function automatic oflow_pkg::apb_data_t field_mask(input int idx);
		if (idx < 6)
			return (32'd1 << oflow_pkg::WEIGHT_LEN) - 1;
		else if (idx == 6)
			return (32'd1 << oflow_pkg::SCORE_LEN) - 1;
		return (32'd1 << oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH) - 1;
	endfunction

	task automatic write_reg(input int idx, input oflow_pkg::apb_data_t value);
		apb_write(oflow_pkg::apb_addr_t'(idx * 4), value, 1'b1);
		shadow[idx] = value & field_mask(idx);
	endtask

	task automatic random_box(output oflow_pkg::bbox_t b);
		b.x      = oflow_pkg::coord_t'($random(seed));
		b.y      = oflow_pkg::coord_t'($random(seed));
		b.width  = oflow_pkg::coord_t'($random(seed));
		b.height = oflow_pkg::coord_t'($random(seed));
		b.color1 = oflow_pkg::coord_t'($random(seed));
		b.color2 = oflow_pkg::coord_t'($random(seed));
	endtask

	task automatic make_pair(output oflow_pkg::bbox_pair_t p);
		random_box(p.det);
		random_box(p.trk.box);
		p.trk.age = oflow_pkg::hist_len_t'($random(seed));
		p.trk.id  = oflow_pkg::track_id_t'($random(seed));
	endtask

	// expected result is due three edges later
	task automatic send_pair(input oflow_pkg::bbox_pair_t p);
		@(negedge clk);
		pair_valid = 1'b1;
		pair       = p;
		exp_q.push_back(model_result(p));
		cyc_q.push_back(cycle + 3);
	endtask

	task automatic drain_pipeline();
		@(negedge clk);
		pair_valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("test %s done, %0d errors", name, err_count - errs_before);
	endtask

	// ----------------------------------------------------------
	// result monitor and cycle limit
	// ----------------------------------------------------------
	always @(negedge clk)
	begin
		if (reset_N && result_valid)
		begin
			if (exp_q.size() == 0)
				note_error("result_valid pulsed with no pair in flight");
			else
			begin
				due_cycle = cyc_q.pop_front();
				check_result("result", result, exp_q.pop_front());
				if (cycle != due_cycle)
					note_error($sformatf("result arrived at cycle %0d, expected cycle %0d",
						cycle, due_cycle));
			end
		end
	end

	always @(posedge clk)
	begin
		cycle++;
		if (cycle >= LIMIT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// tests
	// ----------------------------------------------------------
	initial
	begin
		oflow_pkg::apb_data_t  rd;
		oflow_pkg::bbox_pair_t p;
		oflow_pkg::match_result_t ref_r;
		int errs;
		int nf;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		pair_valid = 1'b0;
		pair       = '0;
		for (int i = 0; i < 8; i++)
			shadow[i] = '0;
		@(posedge reset_N);

		// reset values
		errs = err_count;
		check_flag("idle pready", pready, 1'b0);
		for (int i = 0; i < 8; i++)
		begin
			apb_read(oflow_pkg::apb_addr_t'(i * 4), 1'b1, rd);
			check_data($sformatf("reset value of reg %0d", i), rd, '0);
		end
		report_test("reset_values", errs);

		// write, read back, unmapped accesses
		errs = err_count;
		for (int i = 0; i < 8; i++)
		begin
			write_reg(i, oflow_pkg::apb_data_t'($random(seed)));
			apb_read(oflow_pkg::apb_addr_t'(i * 4), 1'b1, rd);
			check_data($sformatf("readback of reg %0d", i), rd, shadow[i]);
		end
		apb_write(8'h20, oflow_pkg::apb_data_t'($random(seed)), 1'b0);
		apb_write(8'h1E, oflow_pkg::apb_data_t'($random(seed)), 1'b0);
		apb_read(8'h20, 1'b0, rd);
		check_data("unmapped read 0x20", rd, '0);
		apb_read(8'hFC, 1'b0, rd);
		check_data("unmapped read 0xFC", rd, '0);
		for (int i = 0; i < 8; i++)
		begin
			apb_read(oflow_pkg::apb_addr_t'(i * 4), 1'b1, rd);
			check_data($sformatf("reg %0d after unmapped writes", i), rd, shadow[i]);
		end
		report_test("register_access", errs);

		// random weights, back to back stream
		errs = err_count;
		for (int i = 0; i < 6; i++)
			write_reg(i, oflow_pkg::apb_data_t'($random(seed)));
		write_reg(6, oflow_pkg::apb_data_t'($unsigned($random(seed)) % 300000));
		write_reg(7, oflow_pkg::apb_data_t'($random(seed)));
		for (int n = 0; n < NUM_PAIRS; n++)
		begin
			make_pair(p);
			send_pair(p);
		end
		drain_pipeline();
		report_test("random_stream", errs);

		// old tracks, zero threshold so only expiry blocks a match
		errs = err_count;
		nf = int'($unsigned($random(seed)) % 7);
		write_reg(7, oflow_pkg::apb_data_t'(nf));
		write_reg(6, '0);
		for (int n = 0; n < NUM_EXPIRED; n++)
		begin
			make_pair(p);
			p.trk.age = oflow_pkg::hist_len_t'(nf + 1 + int'($unsigned($random(seed)) % (7 - nf)));
			send_pair(p);
		end
		drain_pipeline();
		report_test("expired_tracks", errs);

		// identical boxes, threshold at the score and one above
		errs = err_count;
		write_reg(7, 32'd7);
		for (int n = 0; n < NUM_TH_ROUNDS; n++)
		begin
			make_pair(p);
			p.trk.box = p.det;
			ref_r = model_result(p);
			write_reg(6, oflow_pkg::apb_data_t'(ref_r.score));
			send_pair(p);
			drain_pipeline();
			write_reg(6, oflow_pkg::apb_data_t'(ref_r.score) + 32'd1);
			send_pair(p);
			drain_pipeline();
		end
		report_test("threshold_edges", errs);

		$display("checks passed %0d, failed %0d", pass_count, err_count);
		if (err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
source/oflow_pkg.sv
source/oflow_reg_file.sv
source/oflow_feature_diff.sv
source/oflow_score_calc.sv
source/oflow_match_decide.sv
source/oflow_core.sv
tb/oflow_clk_gen.sv
tb/oflow_core_tb.sv
